/* flist.f */
+incdir+.
ifm_pkg.sv
ifm_chunk_if.sv
data_chunk.sv
sparse_pri_enc.sv
data_addr_cal.sv
bank_ctrl.sv
data_chunk_top_ifm.sv
sparse_ifm_buffer.sv
sparse_ifm_buffer_props.sv
tb_sparse_ifm_buffer.sv

/* Bender.yml */
package:
  name: sparse_ifm_buffer

sources:
  - include_dirs:
      - .
    files:
      - ifm_pkg.sv
      - ifm_chunk_if.sv
      - data_chunk.sv
      - sparse_pri_enc.sv
      - data_addr_cal.sv
      - bank_ctrl.sv
      - data_chunk_top_ifm.sv
      - sparse_ifm_buffer.sv
  - target: test
    include_dirs:
      - .
    files:
      - sparse_ifm_buffer_props.sv
      - tb_sparse_ifm_buffer.sv

/* tb_sparse_ifm_buffer.sv */
`timescale 1ns/10ps
`include "ifm_consts.svh"

module tb_sparse_ifm_buffer;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY  = 5;
	localparam int N_RAND     = 6;
	localparam int N_TESTS    = N_RAND + 5;
	// 16 write and 40 read cycles per test plus reset and slack
	localparam int WATCHDOG_CYCLES = N_TESTS * (16 + 40) + 16 + 200;

	typedef struct packed {
		ifm_pkg::elem_pos_t pos;
		ifm_pkg::byte_t     val;
	} beat_t;

	logic                                clk;
	logic                                arst_n;
	ifm_pkg::segmap_t                    wr_sparsemap;
	ifm_pkg::byte_t [`IFM_BUS_SIZE-1:0]  wr_data;
	logic                                wr_valid;
	ifm_pkg::seg_idx_t                   wr_count;
	logic                                wr_done;
	logic                                wr_ready;
	logic                                rd_start;
	logic                                rd_ready;
	ifm_pkg::byte_t                      rd_data;
	logic                                rd_data_valid;
	ifm_pkg::elem_pos_t                  rd_pos;
	logic                                rd_done;

	// Model of the read stream in write order
	beat_t        exp_q[$];
	int           chunk_len_q[$];
	int           exp_len;
	int           got_cnt = 0;
	int           test_errs = 0;
	int           props_base = 0;
	int           pass_cnt = 0;
	int           fail_cnt = 0;
	string        test_name = "none";
	logic [31:0]  rng_state = 32'd63707;

	sparse_ifm_buffer uut (
		.clk_i             (clk),
		.arst_n_i          (arst_n),
		.wr_sparsemap_i    (wr_sparsemap),
		.wr_nonzero_data_i (wr_data),
		.wr_valid_i        (wr_valid),
		.wr_count_i        (wr_count),
		.wr_done_i         (wr_done),
		.wr_ready_o        (wr_ready),
		.rd_start_i        (rd_start),
		.rd_ready_o        (rd_ready),
		.rd_data_o         (rd_data),
		.rd_data_valid_o   (rd_data_valid),
		.rd_pos_o          (rd_pos),
		.rd_done_o         (rd_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic step();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic start_test(input string name);
		test_name  = name;
		test_errs  = 0;
		props_base = uut.u_props.err_cnt;
	endtask

	task automatic report_test();
		int errs;
		errs = test_errs + (uut.u_props.err_cnt - props_base);
		if (errs == 0) begin
			$display("test %s: passed", test_name);
			pass_cnt++;
		end else begin
			$display("test %s: failed with %0d errors", test_name, errs);
			fail_cnt++;
		end
	endtask

	task automatic expect_level(input string sig, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("mismatch %s: %s expected %0b actual %0b", test_name, sig, exp, act);
			test_errs++;
		end
	endtask

	//////////////////////////////////////////////////
	// Chunk write and read
	//////////////////////////////////////////////////

	task automatic write_chunk(input logic [31:0] map);
		logic [31:0] r;
		int          rank;
		int          waited;
		waited = 0;
		while (!wr_ready && waited < 64) begin
			step();
			waited++;
		end
		assert (wr_ready) else begin
			$display("%s: write side never became ready", test_name);
			test_errs++;
		end
		if (wr_ready) begin
			for (int k = 0; k < `IFM_WR_DAT_CYC_NUM; k++) begin
				rank = 0;
				// Lanes above the popcount carry junk
				for (int i = 0; i < `IFM_BUS_SIZE; i++) begin
					r = xorshift32();
					wr_data[i] = r[7:0];
				end
				for (int i = 0; i < `IFM_BUS_SIZE; i++) begin
					if (map[k * `IFM_BUS_SIZE + i]) begin
						r = xorshift32();
						wr_data[rank] = (r[7:0] == 8'h00) ? 8'h01 : r[7:0];
						exp_q.push_back(beat_t'{pos: ifm_pkg::elem_pos_t'(k * `IFM_BUS_SIZE + i),
							val: wr_data[rank]});
						rank++;
					end
				end
				wr_sparsemap = map[k * `IFM_BUS_SIZE +: `IFM_BUS_SIZE];
				wr_count     = ifm_pkg::seg_idx_t'(k);
				wr_valid     = 1'b1;
				step();
			end
			wr_valid = 1'b0;
			wr_done  = 1'b1;
			step();
			wr_done = 1'b0;
			chunk_len_q.push_back($countones(map));
		end
	endtask

	task automatic read_chunk();
		int waited;
		waited = 0;
		while (!rd_ready && waited < 64) begin
			step();
			waited++;
		end
		assert (rd_ready) else begin
			$display("%s: no full bank to read", test_name);
			test_errs++;
		end
		rd_start = 1'b1;
		step();
		rd_start = 1'b0;
		waited = 0;
		while (!rd_done && waited < 48) begin
			@(negedge clk);
			waited++;
		end
		assert (rd_done) else begin
			$display("%s: rd_done_o never came after the read start", test_name);
			test_errs++;
		end
		step();
	endtask

	// Read beats against the head of the model queue
	always @(negedge clk) begin
		if (arst_n && rd_data_valid) begin
			assert (exp_q.size() > 0) else begin
				$display("%s: extra data beat at position %0d", test_name, rd_pos);
				test_errs++;
			end
			if (exp_q.size() > 0) begin
				assert (rd_pos == exp_q[0].pos) else begin
					$display("mismatch %s: position expected %0d actual %0d",
						test_name, exp_q[0].pos, rd_pos);
					test_errs++;
				end
				assert (rd_data == exp_q[0].val) else begin
					$display("mismatch %s: data expected %02h actual %02h",
						test_name, exp_q[0].val, rd_data);
					test_errs++;
				end
				void'(exp_q.pop_front());
			end
			got_cnt++;
		end
		if (arst_n && rd_done) begin
			exp_len = (chunk_len_q.size() > 0) ? chunk_len_q.pop_front() : 0;
			assert (got_cnt == exp_len) else begin
				$display("%s: read gave %0d data beats but the chunk held %0d",
					test_name, got_cnt, exp_len);
				test_errs++;
			end
			// Drop what a short read left behind
			while (got_cnt < exp_len && exp_q.size() > 0) begin
				void'(exp_q.pop_front());
				got_cnt++;
			end
			got_cnt = 0;
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] map;
		arst_n       = 1'b0;
		wr_sparsemap = '0;
		wr_data      = '0;
		wr_valid     = 1'b0;
		wr_count     = '0;
		wr_done      = 1'b0;
		rd_start     = 1'b0;
		repeat (16) @(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		step();

		start_test("reset_state");
		expect_level("wr_ready_o", 1'b1, wr_ready);
		expect_level("rd_ready_o", 1'b0, rd_ready);
		expect_level("rd_data_valid_o", 1'b0, rd_data_valid);
		expect_level("rd_done_o", 1'b0, rd_done);
		report_test();

		start_test("dense");
		write_chunk('1);
		read_chunk();
		report_test();

		for (int i = 0; i < N_RAND; i++) begin
			start_test($sformatf("sparse_%0d", i));
			map = xorshift32();
			if (i % 2 == 0) map = map & xorshift32();
			// Empty segment between two filled ones
			if (i == 1) map[15:8] = '0;
			write_chunk(map);
			read_chunk();
			report_test();
		end

		start_test("all_zero");
		write_chunk('0);
		read_chunk();
		report_test();

		// Second chunk fills bank 1 while bank 0 drains
		start_test("ping_pong");
		write_chunk(xorshift32());
		fork
			read_chunk();
			write_chunk(xorshift32());
		join
		read_chunk();
		report_test();

		start_test("both_full");
		write_chunk(xorshift32());
		write_chunk(xorshift32() | xorshift32());
		expect_level("wr_ready_o", 1'b0, wr_ready);
		read_chunk();
		expect_level("wr_ready_o", 1'b1, wr_ready);
		read_chunk();
		report_test();

		if (exp_q.size() != 0) begin
			$display("%0d written values were never read back", exp_q.size());
		end
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && exp_q.size() == 0 && uut.u_props.err_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired during test %s, the run did not finish", test_name);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* sparse_ifm_buffer_props.sv */
`timescale 1ns/10ps

module sparse_ifm_buffer_props (
	input logic clk_i,
	input logic arst_n_i,
	input logic wr_valid_i,
	input logic wr_done_i,
	input logic wr_ready_i,
	input logic rd_start_i,
	input logic rd_ready_i,
	input logic rd_data_valid_i,
	input logic rd_done_i
);

	int unsigned err_cnt = 0;
	logic        armed_q;

	// Set by an accepted start, cleared by the done pulse
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) armed_q <= 1'b0;
		else if (rd_done_i) armed_q <= 1'b0;
		else if (rd_start_i && rd_ready_i) armed_q <= 1'b1;
	end

	wr_only_when_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(wr_valid_i || wr_done_i) |-> wr_ready_i) else begin
		$error("write strobe while wr_ready_o was low");
		err_cnt++;
	end

	done_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rd_done_i |=> !rd_done_i) else begin
		$error("rd_done_o held for more than one cycle");
		err_cnt++;
	end

	valid_after_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rd_data_valid_i |-> armed_q) else begin
		$error("rd_data_valid_o without a read start since the last done");
		err_cnt++;
	end

	done_after_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rd_done_i |-> armed_q) else begin
		$error("rd_done_o without a read start");
		err_cnt++;
	end

endmodule

bind sparse_ifm_buffer sparse_ifm_buffer_props u_props (
	.clk_i           (clk_i),
	.arst_n_i        (arst_n_i),
	.wr_valid_i      (wr_valid_i),
	.wr_done_i       (wr_done_i),
	.wr_ready_i      (wr_ready_o),
	.rd_start_i      (rd_start_i),
	.rd_ready_i      (rd_ready_o),
	.rd_data_valid_i (rd_data_valid_o),
	.rd_done_i       (rd_done_o)
);

/* sparse_ifm_buffer.sv */
`timescale 1ns/10ps
`include "ifm_consts.svh"

module sparse_ifm_buffer (
	input  logic                                clk_i,
	input  logic                                arst_n_i,
	input  ifm_pkg::segmap_t                    wr_sparsemap_i,
	input  ifm_pkg::byte_t [`IFM_BUS_SIZE-1:0]  wr_nonzero_data_i,
	input  logic                                wr_valid_i,
	input  ifm_pkg::seg_idx_t                   wr_count_i,
	input  logic                                wr_done_i,
	output logic                                wr_ready_o,
	input  logic                                rd_start_i,
	output logic                                rd_ready_o,
	output ifm_pkg::byte_t                      rd_data_o,
	output logic                                rd_data_valid_o,
	output ifm_pkg::elem_pos_t                  rd_pos_o,
	output logic                                rd_done_o
);

	ifm_pkg::bank_t  wr_sel;
	ifm_pkg::bank_t  rd_sel;
	logic [1:0]      clear;

	// Bank bookkeeping beside the datapath
	bank_ctrl u_bank_ctrl (
		.clk_i, .arst_n_i,
		.wr_done_i  (wr_done_i),
		.rd_done_i  (rd_done_o),
		.wr_sel_o   (wr_sel),
		.rd_sel_o   (rd_sel),
		.wr_ready_o (wr_ready_o),
		.rd_ready_o (rd_ready_o),
		.clear_o    (clear)
	);

	data_chunk_top_ifm u_data_chunk_top_ifm (
		.clk_i, .arst_n_i,
		.wr_sparsemap_i, .wr_nonzero_data_i, .wr_valid_i, .wr_count_i,
		.wr_sel_i        (wr_sel),
		.rd_sel_i        (rd_sel),
		.clear_i         (clear),
		// Start only counts with a full read bank
		.rd_start_i      (rd_start_i && rd_ready_o),
		.rd_data_o, .rd_data_valid_o, .rd_pos_o, .rd_done_o
	);

endmodule

/* data_chunk_top_ifm.sv */
`timescale 1ns/10ps
`include "ifm_consts.svh"

module data_chunk_top_ifm (
	input  logic                                clk_i,
	input  logic                                arst_n_i,
	input  ifm_pkg::segmap_t                    wr_sparsemap_i,
	input  ifm_pkg::byte_t [`IFM_BUS_SIZE-1:0]  wr_nonzero_data_i,
	input  logic                                wr_valid_i,
	input  ifm_pkg::seg_idx_t                   wr_count_i,
	input  ifm_pkg::bank_t                      wr_sel_i,
	input  ifm_pkg::bank_t                      rd_sel_i,
	input  logic [1:0]                          clear_i,
	input  logic                                rd_start_i,
	output ifm_pkg::byte_t                      rd_data_o,
	output logic                                rd_data_valid_o,
	output ifm_pkg::elem_pos_t                  rd_pos_o,
	output logic                                rd_done_o
);

	ifm_pkg::byte_t        rd_data_w [2];
	ifm_pkg::segmap_t      seg_map_w [2];
	ifm_pkg::segmap_t      seg_map;
	ifm_pkg::seg_idx_t     seg_addr;
	ifm_pkg::data_addr_t   data_addr;
	ifm_pkg::lane_t        match_lane;
	logic                  match, seg_end, chunk_start, scan_done;

	//////////////////////////////////////////////////
	// Ping-pong banks
	//////////////////////////////////////////////////

	for (genvar b = 0; b < 2; b++) begin : g_bank
		chunk_wr_if wr_if ();
		chunk_rd_if rd_if ();
		logic sel_rd;

		assign wr_if.sparsemap = wr_sparsemap_i;
		assign wr_if.data      = wr_nonzero_data_i;
		assign wr_if.count     = wr_count_i;
		assign wr_if.valid     = wr_valid_i && (wr_sel_i == ifm_pkg::bank_t'(b));

		// Idle bank sees address zero
		assign sel_rd           = (rd_sel_i == ifm_pkg::bank_t'(b));
		assign rd_if.data_addr  = sel_rd ? data_addr : '0;
		assign rd_if.seg_addr   = sel_rd ? seg_addr : '0;
		assign rd_data_w[b]     = rd_if.data;
		assign seg_map_w[b]     = rd_if.seg_map;

		data_chunk u_data_chunk (
			.clk_i    (clk_i),
			.arst_n_i (arst_n_i),
			.wr       (wr_if),
			.rd       (rd_if),
			.clear_i  (clear_i[b])
		);
	end

	assign seg_map   = seg_map_w[rd_sel_i];
	assign rd_data_o = rd_data_w[rd_sel_i];

	sparse_pri_enc u_sparse_pri_enc (
		.clk_i, .arst_n_i,
		.start_i       (rd_start_i),
		.seg_map_i     (seg_map),
		.seg_addr_o    (seg_addr),
		.match_o       (match),
		.match_lane_o  (match_lane),
		.seg_end_o     (seg_end),
		.chunk_start_o (chunk_start),
		.done_o        (scan_done)
	);

	data_addr_cal u_data_addr_cal (
		.clk_i, .arst_n_i,
		.match_i       (match),
		.seg_end_i     (seg_end),
		.chunk_start_i (chunk_start),
		.match_lane_i  (match_lane),
		.seg_map_i     (seg_map),
		.data_addr_o   (data_addr)
	);

	// Line up strobe, position and done with the registered data
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_data_valid_o <= 1'b0;
			rd_done_o       <= 1'b0;
		end else begin
			rd_data_valid_o <= match;
			rd_done_o       <= scan_done;
		end
	end

	always_ff @(posedge clk_i) begin
		rd_pos_o <= {seg_addr, match_lane};
	end

endmodule

/* bank_ctrl.sv */
`timescale 1ns/10ps

module bank_ctrl (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  logic             wr_done_i,
	input  logic             rd_done_i,
	output ifm_pkg::bank_t   wr_sel_o,
	output ifm_pkg::bank_t   rd_sel_o,
	output logic             wr_ready_o,
	output logic             rd_ready_o,
	output logic [1:0]       clear_o
);

	logic [1:0]        full_q;
	logic [1:0]        full_d;
	ifm_pkg::bank_t    wr_sel_d;

	// Next full flags, close on write done and free on read done
	always_comb begin
		full_d = full_q;
		if (wr_done_i) full_d[wr_sel_o] = 1'b1;
		if (rd_done_i) full_d[rd_sel_o] = 1'b0;
	end

	// Move the writer on as soon as the other bank is empty
	assign wr_sel_d = (full_d[wr_sel_o] && !full_d[~wr_sel_o]) ? ~wr_sel_o : wr_sel_o;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			full_q   <= '0;
			wr_sel_o <= 1'b0;
			rd_sel_o <= 1'b0;
		end else begin
			full_q   <= full_d;
			wr_sel_o <= wr_sel_d;
			if (rd_done_i) rd_sel_o <= ~rd_sel_o;
		end
	end

	assign wr_ready_o = !full_q[wr_sel_o];
	// Not ready on the done cycle, the bank is being released
	assign rd_ready_o = full_q[rd_sel_o] && !rd_done_i;

	assign clear_o[0] = rd_done_i && (rd_sel_o == 1'b0);
	assign clear_o[1] = rd_done_i && (rd_sel_o == 1'b1);

endmodule

/* data_addr_cal.sv */
`timescale 1ns/10ps
`include "ifm_consts.svh"

module data_addr_cal (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 match_i,
	input  logic                 seg_end_i,
	input  logic                 chunk_start_i,
	input  ifm_pkg::lane_t       match_lane_i,
	input  ifm_pkg::segmap_t     seg_map_i,
	output ifm_pkg::data_addr_t  data_addr_o
);

	ifm_pkg::data_addr_t   base_q;
	ifm_pkg::data_addr_t   seg_pop;
	ifm_pkg::data_addr_t   below_pop;
	ifm_pkg::segmap_t      below_mask;

	//////////////////////////////////////////////////
	// Prefix count inside the segment
	//////////////////////////////////////////////////

	// Bits strictly below the matched lane
	assign below_mask = (ifm_pkg::segmap_t'(1) << match_lane_i) - ifm_pkg::segmap_t'(1);
	assign below_pop  = ifm_pkg::seg_popcount(seg_map_i & below_mask);
	assign seg_pop    = ifm_pkg::seg_popcount(seg_map_i);

	// Without a match the base is the next free slot anyway
	assign data_addr_o = match_i ? (base_q + below_pop) : base_q;

	//////////////////////////////////////////////////
	// Running base over earlier segments
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			base_q <= '0;
		end else if (chunk_start_i) begin
			base_q <= '0;
		end else if (seg_end_i) begin
			base_q <= base_q + seg_pop;
		end
	end

endmodule

/* sparse_pri_enc.sv */
`timescale 1ns/10ps
`include "ifm_consts.svh"

module sparse_pri_enc (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 start_i,
	input  ifm_pkg::segmap_t     seg_map_i,
	output ifm_pkg::seg_idx_t    seg_addr_o,
	output logic                 match_o,
	output ifm_pkg::lane_t       match_lane_o,
	output logic                 seg_end_o,
	output logic                 chunk_start_o,
	output logic                 done_o
);

	localparam ifm_pkg::seg_idx_t LAST_SEG = ifm_pkg::seg_idx_t'(`IFM_RD_DAT_CYC_NUM - 1);

	ifm_pkg::scan_state_e  state_q;
	ifm_pkg::segmap_t      taken_q;
	ifm_pkg::segmap_t      remain;
	ifm_pkg::segmap_t      rest;

	// Bits of the segment not handed out yet
	assign remain = seg_map_i & ~taken_q;
	assign rest   = remain & (remain - ifm_pkg::segmap_t'(1));

	// Lowest remaining set bit
	always_comb begin
		match_lane_o = '0;
		for (int i = `IFM_PREFIX_SUM_SIZE - 1; i >= 0; i--) begin
			if (remain[i]) begin
				match_lane_o = ifm_pkg::lane_t'(i);
			end
		end
	end

	assign match_o       = (state_q == ifm_pkg::scan) && (remain != '0);
	// Empty segment or last bit taken
	assign seg_end_o     = (state_q == ifm_pkg::scan) && (rest == '0);
	assign chunk_start_o = (state_q == ifm_pkg::idle) && start_i;
	assign done_o        = (state_q == ifm_pkg::done);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= ifm_pkg::idle;
			seg_addr_o <= '0;
			taken_q    <= '0;
		end else begin
			case (state_q)
				ifm_pkg::idle: begin
					if (start_i) begin
						state_q    <= ifm_pkg::scan;
						seg_addr_o <= '0;
						taken_q    <= '0;
					end
				end
				ifm_pkg::scan: begin
					if (seg_end_o) begin
						taken_q <= '0;
						if (seg_addr_o == LAST_SEG) state_q <= ifm_pkg::done;
						else seg_addr_o <= seg_addr_o + ifm_pkg::seg_idx_t'(1);
					end else begin
						taken_q <= taken_q | (ifm_pkg::segmap_t'(1) << match_lane_o);
					end
				end
				default: state_q <= ifm_pkg::idle;
			endcase
		end
	end

endmodule

/* data_chunk.sv */
`timescale 1ns/10ps
`include "ifm_consts.svh"

module data_chunk (
	input  logic           clk_i,
	input  logic           arst_n_i,
	chunk_wr_if.dst        wr,
	chunk_rd_if.bank       rd,
	input  logic           clear_i
);

	ifm_pkg::byte_t        mem [`IFM_CHUNK_SIZE];
	ifm_pkg::segmap_t      seg_q [`IFM_RD_DAT_CYC_NUM];
	ifm_pkg::data_addr_t   wr_ptr_q;
	ifm_pkg::data_addr_t   wr_pop;

	ifm_pkg::data_addr_t   lane_addr [`IFM_BUS_SIZE];
	logic [`IFM_BUS_SIZE-1:0] lane_en;

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////

	assign wr_pop = ifm_pkg::seg_popcount(wr.sparsemap);

	// Lanes are packed low, only the first popcount lanes carry data
	always_comb begin
		for (int i = 0; i < `IFM_BUS_SIZE; i++) begin
			lane_addr[i] = wr_ptr_q + ifm_pkg::data_addr_t'(i);
			lane_en[i]   = wr.valid
				&& (ifm_pkg::data_addr_t'(i) < wr_pop)
				&& (lane_addr[i] < ifm_pkg::data_addr_t'(`IFM_CHUNK_SIZE));
		end
	end

	always_ff @(posedge clk_i) begin
		for (int i = 0; i < `IFM_BUS_SIZE; i++) begin
			if (lane_en[i]) begin
				mem[ifm_pkg::elem_pos_t'(lane_addr[i])] <= wr.data[i];
			end
		end
	end

	// Fill pointer and sparsemap segments
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			for (int s = 0; s < `IFM_RD_DAT_CYC_NUM; s++) begin
				seg_q[s] <= '0;
			end
		end else if (clear_i) begin
			wr_ptr_q <= '0;
			for (int s = 0; s < `IFM_RD_DAT_CYC_NUM; s++) begin
				seg_q[s] <= '0;
			end
		end else if (wr.valid) begin
			wr_ptr_q          <= wr_ptr_q + wr_pop;
			seg_q[wr.count]   <= wr.sparsemap;
		end
	end

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////

	// One cycle data latency
	always_ff @(posedge clk_i) begin
		rd.data <= mem[ifm_pkg::elem_pos_t'(rd.data_addr)];
	end

	assign rd.seg_map = seg_q[rd.seg_addr];

endmodule

/* ifm_chunk_if.sv */
`timescale 1ns/10ps
`include "ifm_consts.svh"

// One compressed write beat towards a bank
interface chunk_wr_if;

	ifm_pkg::segmap_t                       sparsemap;
	ifm_pkg::byte_t [`IFM_BUS_SIZE-1:0]     data;
	logic                                   valid;
	ifm_pkg::seg_idx_t                      count;

	modport src (
		output sparsemap,
		output data,
		output valid,
		output count
	);

	modport dst (
		input sparsemap,
		input data,
		input valid,
		input count
	);

endinterface

// Read port of a bank, data is registered and the map is not
interface chunk_rd_if;

	ifm_pkg::data_addr_t                    data_addr;
	ifm_pkg::byte_t                         data;
	ifm_pkg::seg_idx_t                      seg_addr;
	ifm_pkg::segmap_t                       seg_map;

	modport host (
		output data_addr,
		output seg_addr,
		input  data,
		input  seg_map
	);

	modport bank (
		input  data_addr,
		input  seg_addr,
		output data,
		output seg_map
	);

endinterface

/* ifm_pkg.sv */
`include "ifm_consts.svh"

package ifm_pkg;

	typedef logic [7:0]                                  byte_t;
	typedef logic [`IFM_PREFIX_SUM_SIZE-1:0]             segmap_t;
	typedef logic [$clog2(`IFM_RD_DAT_CYC_NUM)-1:0]      seg_idx_t;
	typedef logic [$clog2(`IFM_PREFIX_SUM_SIZE)-1:0]     lane_t;
	// One extra bit, can point one past the chunk
	typedef logic [$clog2(`IFM_CHUNK_SIZE):0]            data_addr_t;
	typedef logic [$clog2(`IFM_CHUNK_SIZE)-1:0]          elem_pos_t;
	typedef logic                                        bank_t;

	typedef enum logic [1:0] {
		idle,
		scan,
		done
	} scan_state_e;

	// Number of nonzeros flagged in one segment
	function automatic data_addr_t seg_popcount(input segmap_t map);
		data_addr_t cnt;
		cnt = '0;
		for (int i = 0; i < `IFM_PREFIX_SUM_SIZE; i++) begin
			cnt = cnt + data_addr_t'(map[i]);
		end
		return cnt;
	endfunction

endpackage

/* ifm_consts.svh */
`ifndef IFM_CONSTS_SVH
`define IFM_CONSTS_SVH

//////////////////////////////////////////////////
// Write side
//////////////////////////////////////////////////

// Sparsemap bits and data lanes per write beat
`define IFM_BUS_SIZE 8

// Write beats needed to fill one chunk
`define IFM_WR_DAT_CYC_NUM 4

//////////////////////////////////////////////////
// Chunk and read side
//////////////////////////////////////////////////

// Elements per chunk, dense count
`define IFM_CHUNK_SIZE 32

// One sparsemap segment as seen by the scanner
`define IFM_PREFIX_SUM_SIZE 8
`define IFM_RD_DAT_CYC_NUM 4

`endif
